// File: verilog/cpuParams.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data RAM size in 32-bit words
`define DMEM_WORDS 64

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// 1-bit control levels
`define ENABLE 1'b1
`define DISABLE 1'b0

`endif

// File: verilog/cpuPkg.sv
package cpuPkg;

  typedef logic [31:0] BasicData; // register and memory word
  typedef logic [31:0] InstAddr; // byte address of an instruction
  typedef logic [4:0] RegAddr; // x0..x31
  typedef logic [31:0] Instruction; // raw instruction bits
  typedef logic [6:0] Opcode; // inst[6:0]

  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } AluOp;

  // where an ALU operand comes from; NONE reads as zero
  typedef enum logic [1:0] {
    OP_TYPE_NONE,
    OP_TYPE_REG,
    OP_TYPE_IMM
  } OpType;

  localparam Opcode OPCODE_OP = 7'b0110011;
  localparam Opcode OPCODE_OP_IMM = 7'b0010011;
  localparam Opcode OPCODE_LUI = 7'b0110111;
  localparam Opcode OPCODE_LOAD = 7'b0000011;
  localparam Opcode OPCODE_STORE = 7'b0100011;
  localparam Opcode OPCODE_SYSTEM = 7'b1110011;

endpackage

// File: verilog/decoder.sv
`include "cpuParams.svh"

module decoder (
  input  cpuPkg::Instruction inst,
  output cpuPkg::RegAddr     src1Reg,
  output cpuPkg::RegAddr     src2Reg,
  output cpuPkg::RegAddr     dstReg,
  output cpuPkg::BasicData   imm,
  output cpuPkg::AluOp       aluOp,
  output cpuPkg::OpType      op1Type,
  output cpuPkg::OpType      op2Type,
  output logic               rs1Used,
  output logic               rs2Used,
  output logic               regWEnable,
  output logic               isLoad,
  output logic               isStore,
  output logic               isHalt
);

  cpuPkg::Opcode opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic regWrite; // writes rd, before the x0 filter
  cpuPkg::BasicData immI;
  cpuPkg::BasicData immS;
  cpuPkg::BasicData immU;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign src1Reg = inst[19:15];
  assign src2Reg = inst[24:20];
  assign dstReg = inst[11:7];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immU = {inst[31:12], 12'h000};

  // a write to x0 is no write at all
  assign regWEnable = regWrite && (dstReg != '0);

  always_comb begin
    imm = '0;
    aluOp = cpuPkg::ALU_NOP;
    op1Type = cpuPkg::OP_TYPE_NONE;
    op2Type = cpuPkg::OP_TYPE_NONE;
    rs1Used = `DISABLE;
    rs2Used = `DISABLE;
    regWrite = `DISABLE;
    isLoad = `DISABLE;
    isStore = `DISABLE;
    isHalt = `DISABLE;
    case (opcode)
      cpuPkg::OPCODE_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: aluOp = cpuPkg::ALU_ADD;
          10'b0100000_000: aluOp = cpuPkg::ALU_SUB;
          10'b0000000_111: aluOp = cpuPkg::ALU_AND;
          10'b0000000_110: aluOp = cpuPkg::ALU_OR;
          10'b0000000_100: aluOp = cpuPkg::ALU_XOR;
          10'b0000000_010: aluOp = cpuPkg::ALU_SLT;
          10'b0000000_001: aluOp = cpuPkg::ALU_SLL;
          10'b0000000_101: aluOp = cpuPkg::ALU_SRL;
          default: aluOp = cpuPkg::ALU_NOP; // unsupported, stays a NOP
        endcase
        if (aluOp != cpuPkg::ALU_NOP) begin
          op1Type = cpuPkg::OP_TYPE_REG;
          op2Type = cpuPkg::OP_TYPE_REG;
          rs1Used = `ENABLE;
          rs2Used = `ENABLE;
          regWrite = `ENABLE;
        end
      end
      cpuPkg::OPCODE_OP_IMM: begin
        case (funct3)
          3'b000: aluOp = cpuPkg::ALU_ADD;
          3'b111: aluOp = cpuPkg::ALU_AND;
          3'b110: aluOp = cpuPkg::ALU_OR;
          3'b100: aluOp = cpuPkg::ALU_XOR;
          default: aluOp = cpuPkg::ALU_NOP;
        endcase
        if (aluOp != cpuPkg::ALU_NOP) begin
          imm = immI;
          op1Type = cpuPkg::OP_TYPE_REG;
          op2Type = cpuPkg::OP_TYPE_IMM;
          rs1Used = `ENABLE;
          regWrite = `ENABLE;
        end
      end
      cpuPkg::OPCODE_LUI: begin
        imm = immU;
        aluOp = cpuPkg::ALU_ADD; // 0 + imm
        op2Type = cpuPkg::OP_TYPE_IMM;
        regWrite = `ENABLE;
      end
      cpuPkg::OPCODE_LOAD: begin
        if (funct3 == 3'b010) begin // LW only
          imm = immI;
          aluOp = cpuPkg::ALU_ADD;
          op1Type = cpuPkg::OP_TYPE_REG;
          op2Type = cpuPkg::OP_TYPE_IMM;
          rs1Used = `ENABLE;
          regWrite = `ENABLE;
          isLoad = `ENABLE;
        end
      end
      cpuPkg::OPCODE_STORE: begin
        if (funct3 == 3'b010) begin // SW only
          imm = immS;
          aluOp = cpuPkg::ALU_ADD;
          op1Type = cpuPkg::OP_TYPE_REG;
          op2Type = cpuPkg::OP_TYPE_IMM;
          rs1Used = `ENABLE;
          rs2Used = `ENABLE; // store data
          isStore = `ENABLE;
        end
      end
      cpuPkg::OPCODE_SYSTEM: begin
        isHalt = (inst[31:7] == '0); // ecall
      end
      default: isHalt = `DISABLE;
    endcase
  end

endmodule

// File: verilog/decodeStage.sv
`include "cpuParams.svh"

module decodeStage (
  input  logic               clk,
  input  logic               rstN,
  input  cpuPkg::InstAddr    idPc,
  input  cpuPkg::Instruction idInst,
  input  logic               stall,
  input  cpuPkg::BasicData   rs1Data,
  input  cpuPkg::BasicData   rs2Data,
  output cpuPkg::RegAddr     rs1Addr,
  output cpuPkg::RegAddr     rs2Addr,
  output logic               rs1Used,
  output logic               rs2Used,
  output logic               haltSeen,
  output cpuPkg::InstAddr    exPc,
  output cpuPkg::BasicData   exRs1Data,
  output cpuPkg::BasicData   exRs2Data,
  output cpuPkg::BasicData   exImm,
  output cpuPkg::RegAddr     exRd,
  output cpuPkg::AluOp       exAluOp,
  output cpuPkg::OpType      exOp1Type,
  output cpuPkg::OpType      exOp2Type,
  output logic               exWEnable,
  output logic               exIsLoad,
  output logic               exIsStore,
  output logic               exIsHalt
);

  cpuPkg::RegAddr rdAddr;
  cpuPkg::BasicData imm;
  cpuPkg::AluOp aluOp;
  cpuPkg::OpType op1Type;
  cpuPkg::OpType op2Type;
  logic regWEnable;
  logic isLoad;
  logic isStore;
  logic isHalt;
  logic bubble;

  decoder decoder (
    .inst       (idInst),
    .src1Reg    (rs1Addr), // straight to the register file
    .src2Reg    (rs2Addr),
    .dstReg     (rdAddr),
    .imm        (imm),
    .aluOp      (aluOp),
    .op1Type    (op1Type),
    .op2Type    (op2Type),
    .rs1Used    (rs1Used),
    .rs2Used    (rs2Used),
    .regWEnable (regWEnable),
    .isLoad     (isLoad),
    .isStore    (isStore),
    .isHalt     (isHalt)
  );

  // anything behind an ecall is squashed
  assign bubble = (stall == `ENABLE) || (haltSeen == `ENABLE);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      haltSeen <= `DISABLE;
    end else if (isHalt && !bubble) begin
      haltSeen <= `ENABLE; // ecall issued to execute
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN || bubble) begin
      exAluOp <= cpuPkg::ALU_NOP;
      exOp1Type <= cpuPkg::OP_TYPE_NONE;
      exOp2Type <= cpuPkg::OP_TYPE_NONE;
      exWEnable <= `DISABLE;
      exIsLoad <= `DISABLE;
      exIsStore <= `DISABLE;
      exIsHalt <= `DISABLE;
    end else begin
      exAluOp <= aluOp;
      exOp1Type <= op1Type;
      exOp2Type <= op2Type;
      exWEnable <= regWEnable;
      exIsLoad <= isLoad;
      exIsStore <= isStore;
      exIsHalt <= isHalt;
    end
  end

  // payload, only meaningful behind the control bits
  always_ff @(posedge clk) begin
    exPc <= idPc;
    exRs1Data <= rs1Data;
    exRs2Data <= rs2Data;
    exImm <= imm;
    exRd <= rdAddr;
  end

endmodule

// File: verilog/fetchStage.sv
`include "cpuParams.svh"

module fetchStage (
  input  logic               clk,
  input  logic               rstN,
  input  logic               stall,
  input  logic               haltSeen,
  output cpuPkg::InstAddr    instAddr,
  input  cpuPkg::Instruction instData,
  output cpuPkg::InstAddr    idPc,
  output cpuPkg::Instruction idInst
);

  localparam cpuPkg::Instruction NopInst = 32'h0000_0013; // addi x0, x0, 0

  // instAddr is the PC itself
  always_ff @(posedge clk) begin
    if (!rstN) begin
      instAddr <= `RESET_PC;
      idPc <= `RESET_PC;
      idInst <= NopInst;
    end else if (haltSeen == `ENABLE) begin
      idInst <= NopInst; // PC frozen, feed NOPs
    end else if (stall == `DISABLE) begin
      instAddr <= instAddr + 32'd4;
      idPc <= instAddr;
      idInst <= instData;
    end
  end

endmodule

// File: verilog/registerFile.sv
module registerFile (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::RegAddr   rs1Addr,
  input  cpuPkg::RegAddr   rs2Addr,
  output cpuPkg::BasicData rs1Data,
  output cpuPkg::BasicData rs2Data,
  input  logic             wEnable,
  input  cpuPkg::RegAddr   wAddr,
  input  cpuPkg::BasicData wData
);

  cpuPkg::BasicData regs [32];
  logic writeHit1;
  logic writeHit2;

  // write-through hides the writeback cycle from decode
  assign writeHit1 = wEnable && (wAddr == rs1Addr);
  assign writeHit2 = wEnable && (wAddr == rs2Addr);

  assign rs1Data = (rs1Addr == '0) ? '0 : (writeHit1 ? wData : regs[rs1Addr]);
  assign rs2Data = (rs2Addr == '0) ? '0 : (writeHit2 ? wData : regs[rs2Addr]);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wEnable && (wAddr != '0)) begin
      regs[wAddr] <= wData; // x0 stays zero
    end
  end

endmodule

// File: verilog/hazardUnit.sv
module hazardUnit (
  input  cpuPkg::RegAddr rs1Addr,
  input  cpuPkg::RegAddr rs2Addr,
  input  logic           rs1Used,
  input  logic           rs2Used,
  input  cpuPkg::RegAddr exRd,
  input  logic           exWEnable,
  input  cpuPkg::RegAddr memRd,
  input  logic           memWEnable,
  output logic           stall
);

  logic rs1Busy;
  logic rs2Busy;

  // writeback is covered by the register file write-through
  assign rs1Busy = rs1Used && (rs1Addr != '0) &&
                   ((exWEnable && (exRd == rs1Addr)) || (memWEnable && (memRd == rs1Addr)));
  assign rs2Busy = rs2Used && (rs2Addr != '0) &&
                   ((exWEnable && (exRd == rs2Addr)) || (memWEnable && (memRd == rs2Addr)));

  assign stall = rs1Busy || rs2Busy;

endmodule

// File: verilog/executeStage.sv
`include "cpuParams.svh"

module executeStage (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::InstAddr  exPc,
  input  cpuPkg::BasicData exRs1Data,
  input  cpuPkg::BasicData exRs2Data,
  input  cpuPkg::BasicData exImm,
  input  cpuPkg::RegAddr   exRd,
  input  cpuPkg::AluOp     exAluOp,
  input  cpuPkg::OpType    exOp1Type,
  input  cpuPkg::OpType    exOp2Type,
  input  logic             exWEnable,
  input  logic             exIsLoad,
  input  logic             exIsStore,
  input  logic             exIsHalt,
  output cpuPkg::InstAddr  memPc,
  output cpuPkg::BasicData memResult,
  output cpuPkg::BasicData memStoreData,
  output cpuPkg::RegAddr   memRd,
  output logic             memWEnable,
  output logic             memIsLoad,
  output logic             memIsStore,
  output logic             memIsHalt
);

  cpuPkg::BasicData op1;
  cpuPkg::BasicData op2;
  cpuPkg::BasicData aluResult;

  always_comb begin
    case (exOp1Type)
      cpuPkg::OP_TYPE_REG: op1 = exRs1Data;
      default: op1 = '0; // LUI base
    endcase
    case (exOp2Type)
      cpuPkg::OP_TYPE_REG: op2 = exRs2Data;
      cpuPkg::OP_TYPE_IMM: op2 = exImm;
      default: op2 = '0;
    endcase
  end

  always_comb begin
    case (exAluOp)
      cpuPkg::ALU_ADD: aluResult = op1 + op2;
      cpuPkg::ALU_SUB: aluResult = op1 - op2;
      cpuPkg::ALU_AND: aluResult = op1 & op2;
      cpuPkg::ALU_OR: aluResult = op1 | op2;
      cpuPkg::ALU_XOR: aluResult = op1 ^ op2;
      cpuPkg::ALU_SLT: aluResult = ($signed(op1) < $signed(op2)) ? 32'd1 : 32'd0;
      cpuPkg::ALU_SLL: aluResult = op1 << op2[4:0];
      cpuPkg::ALU_SRL: aluResult = op1 >> op2[4:0]; // logical
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWEnable <= `DISABLE;
      memIsLoad <= `DISABLE;
      memIsStore <= `DISABLE;
      memIsHalt <= `DISABLE;
    end else begin
      memWEnable <= exWEnable;
      memIsLoad <= exIsLoad;
      memIsStore <= exIsStore;
      memIsHalt <= exIsHalt;
    end
  end

  always_ff @(posedge clk) begin
    memPc <= exPc;
    memResult <= aluResult; // data address for LW/SW
    memStoreData <= exRs2Data;
    memRd <= exRd;
  end

endmodule

// File: verilog/memoryStage.sv
`include "cpuParams.svh"

module memoryStage (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::InstAddr  memPc,
  input  cpuPkg::BasicData memResult,
  input  cpuPkg::BasicData memStoreData,
  input  cpuPkg::RegAddr   memRd,
  input  logic             memWEnable,
  input  logic             memIsLoad,
  input  logic             memIsStore,
  input  logic             memIsHalt,
  output logic             retireValid,
  output cpuPkg::RegAddr   retireRd,
  output cpuPkg::BasicData retireData,
  output cpuPkg::InstAddr  retirePc,
  output logic             halted,
  output logic             wbEnable,
  output cpuPkg::RegAddr   wbRd,
  output cpuPkg::BasicData wbData
);

  localparam int AddrMsb = $clog2(`DMEM_WORDS) + 1; // word index above byte offset

  cpuPkg::BasicData dataRam [`DMEM_WORDS];
  logic [AddrMsb-2:0] ramIndex;
  cpuPkg::InstAddr wbPc;

  assign ramIndex = memResult[AddrMsb:2];

  always_ff @(posedge clk) begin
    if (memIsStore == `ENABLE) begin
      dataRam[ramIndex] <= memStoreData;
    end
    wbData <= (memIsLoad == `ENABLE) ? dataRam[ramIndex] : memResult; // sync read
    wbRd <= memRd;
    wbPc <= memPc;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbEnable <= `DISABLE;
      halted <= `DISABLE;
    end else begin
      wbEnable <= memWEnable;
      if (memIsHalt == `ENABLE) begin
        halted <= `ENABLE; // sticky until reset
      end
    end
  end

  // nothing retires once halted
  assign retireValid = wbEnable && (halted == `DISABLE);
  assign retireRd = wbRd;
  assign retireData = wbData;
  assign retirePc = wbPc;

endmodule

// File: verilog/cpuCore.sv
module cpuCore (
  input  logic               clk,
  input  logic               rstN,
  output cpuPkg::InstAddr    instAddr,
  input  cpuPkg::Instruction instData,
  output logic               retireValid,
  output cpuPkg::RegAddr     retireRd,
  output cpuPkg::BasicData   retireData,
  output cpuPkg::InstAddr    retirePc,
  output logic               halted
);

  logic stall;
  logic haltSeen;
  cpuPkg::InstAddr idPc;
  cpuPkg::Instruction idInst;
  cpuPkg::RegAddr rs1Addr;
  cpuPkg::RegAddr rs2Addr;
  logic rs1Used;
  logic rs2Used;
  cpuPkg::BasicData rs1Data;
  cpuPkg::BasicData rs2Data;
  cpuPkg::InstAddr exPc;
  cpuPkg::BasicData exRs1Data;
  cpuPkg::BasicData exRs2Data;
  cpuPkg::BasicData exImm;
  cpuPkg::RegAddr exRd;
  cpuPkg::AluOp exAluOp;
  cpuPkg::OpType exOp1Type;
  cpuPkg::OpType exOp2Type;
  logic exWEnable;
  logic exIsLoad;
  logic exIsStore;
  logic exIsHalt;
  cpuPkg::InstAddr memPc;
  cpuPkg::BasicData memResult;
  cpuPkg::BasicData memStoreData;
  cpuPkg::RegAddr memRd;
  logic memWEnable;
  logic memIsLoad;
  logic memIsStore;
  logic memIsHalt;
  logic wbEnable;
  cpuPkg::RegAddr wbRd;
  cpuPkg::BasicData wbData;

  fetchStage fetch (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .haltSeen (haltSeen),
    .instAddr (instAddr),
    .instData (instData),
    .idPc     (idPc),
    .idInst   (idInst)
  );

  decodeStage decode (
    .clk       (clk),
    .rstN      (rstN),
    .idPc      (idPc),
    .idInst    (idInst),
    .stall     (stall),
    .rs1Data   (rs1Data),
    .rs2Data   (rs2Data),
    .rs1Addr   (rs1Addr),
    .rs2Addr   (rs2Addr),
    .rs1Used   (rs1Used),
    .rs2Used   (rs2Used),
    .haltSeen  (haltSeen),
    .exPc      (exPc),
    .exRs1Data (exRs1Data),
    .exRs2Data (exRs2Data),
    .exImm     (exImm),
    .exRd      (exRd),
    .exAluOp   (exAluOp),
    .exOp1Type (exOp1Type),
    .exOp2Type (exOp2Type),
    .exWEnable (exWEnable),
    .exIsLoad  (exIsLoad),
    .exIsStore (exIsStore),
    .exIsHalt  (exIsHalt)
  );

  registerFile regFile (
    .clk     (clk),
    .rstN    (rstN),
    .rs1Addr (rs1Addr),
    .rs2Addr (rs2Addr),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .wEnable (wbEnable),
    .wAddr   (wbRd),
    .wData   (wbData)
  );

  hazardUnit hazard (
    .rs1Addr    (rs1Addr),
    .rs2Addr    (rs2Addr),
    .rs1Used    (rs1Used),
    .rs2Used    (rs2Used),
    .exRd       (exRd),
    .exWEnable  (exWEnable),
    .memRd      (memRd),
    .memWEnable (memWEnable),
    .stall      (stall)
  );

  executeStage execute (
    .clk          (clk),
    .rstN         (rstN),
    .exPc         (exPc),
    .exRs1Data    (exRs1Data),
    .exRs2Data    (exRs2Data),
    .exImm        (exImm),
    .exRd         (exRd),
    .exAluOp      (exAluOp),
    .exOp1Type    (exOp1Type),
    .exOp2Type    (exOp2Type),
    .exWEnable    (exWEnable),
    .exIsLoad     (exIsLoad),
    .exIsStore    (exIsStore),
    .exIsHalt     (exIsHalt),
    .memPc        (memPc),
    .memResult    (memResult),
    .memStoreData (memStoreData),
    .memRd        (memRd),
    .memWEnable   (memWEnable),
    .memIsLoad    (memIsLoad),
    .memIsStore   (memIsStore),
    .memIsHalt    (memIsHalt)
  );

  memoryStage memory (
    .clk          (clk),
    .rstN         (rstN),
    .memPc        (memPc),
    .memResult    (memResult),
    .memStoreData (memStoreData),
    .memRd        (memRd),
    .memWEnable   (memWEnable),
    .memIsLoad    (memIsLoad),
    .memIsStore   (memIsStore),
    .memIsHalt    (memIsHalt),
    .retireValid  (retireValid),
    .retireRd     (retireRd),
    .retireData   (retireData),
    .retirePc     (retirePc),
    .halted       (halted),
    .wbEnable     (wbEnable),
    .wbRd         (wbRd),
    .wbData       (wbData)
  );

endmodule

// File: dv/cpuCoreTb.sv
`include "cpuParams.svh"

module cpuCoreTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RandLen = 200;
  localparam int ProgLen = RandLen + 3; // LUI/ADDI preload, random body, ECALL
  localparam int CycleLimit = 5 * ProgLen + 50;
  localparam int ExtraCycles = 20;
  localparam cpuPkg::Instruction NopInst = 32'h0000_0013; // addi x0, x0, 0

  // instruction kinds of the generator and the ISA model
  localparam int KindAdd = 0;
  localparam int KindSub = 1;
  localparam int KindAnd = 2;
  localparam int KindOr = 3;
  localparam int KindXor = 4;
  localparam int KindSlt = 5;
  localparam int KindSll = 6;
  localparam int KindSrl = 7;
  localparam int KindAddi = 8;
  localparam int KindAndi = 9;
  localparam int KindOri = 10;
  localparam int KindXori = 11;
  localparam int KindLui = 12;
  localparam int KindLw = 13;
  localparam int KindSw = 14;
  localparam int KindEcall = 15;

  logic clk;
  logic rstN;
  cpuPkg::InstAddr instAddr;
  cpuPkg::Instruction instData;
  logic retireValid;
  cpuPkg::RegAddr retireRd;
  cpuPkg::BasicData retireData;
  cpuPkg::InstAddr retirePc;
  logic halted;

  cpuPkg::Instruction prog [256];
  int kindOf [256];
  cpuPkg::RegAddr rdOf [256];
  cpuPkg::RegAddr rs1Of [256];
  cpuPkg::RegAddr rs2Of [256];
  cpuPkg::BasicData immOf [256];
  bit written [64]; // words stored so far and safe to load

  cpuPkg::BasicData modelRegs [32];
  cpuPkg::BasicData modelMem [64];
  cpuPkg::RegAddr expRd [$];
  cpuPkg::BasicData expData [$];
  cpuPkg::InstAddr expPc [$];

  cpuPkg::RegAddr wantRd;
  cpuPkg::BasicData wantData;
  cpuPkg::InstAddr wantPc;
  integer seed;
  int errorCount;
  int mismatchCount;
  int checkCount;
  int retireCount;
  int cycles;

  cpuCore dut (
    .clk         (clk),
    .rstN        (rstN),
    .instAddr    (instAddr),
    .instData    (instData),
    .retireValid (retireValid),
    .retireRd    (retireRd),
    .retireData  (retireData),
    .retirePc    (retirePc),
    .halted      (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // instruction port answers in the same cycle
  always_comb begin
    if (instAddr[31:10] == '0) begin
      instData = prog[instAddr[9:2]]; // NOP past the program end
    end else begin
      instData = NopInst;
    end
  end

  function automatic cpuPkg::Instruction encodeInst(input int kind, input cpuPkg::RegAddr rd,
      input cpuPkg::RegAddr rs1, input cpuPkg::RegAddr rs2, input cpuPkg::BasicData imm);
    cpuPkg::Instruction word;
    word = NopInst;
    case (kind)
      KindAdd: word = {7'b0000000, rs2, rs1, 3'b000, rd, cpuPkg::OPCODE_OP};
      KindSub: word = {7'b0100000, rs2, rs1, 3'b000, rd, cpuPkg::OPCODE_OP};
      KindAnd: word = {7'b0000000, rs2, rs1, 3'b111, rd, cpuPkg::OPCODE_OP};
      KindOr: word = {7'b0000000, rs2, rs1, 3'b110, rd, cpuPkg::OPCODE_OP};
      KindXor: word = {7'b0000000, rs2, rs1, 3'b100, rd, cpuPkg::OPCODE_OP};
      KindSlt: word = {7'b0000000, rs2, rs1, 3'b010, rd, cpuPkg::OPCODE_OP};
      KindSll: word = {7'b0000000, rs2, rs1, 3'b001, rd, cpuPkg::OPCODE_OP};
      KindSrl: word = {7'b0000000, rs2, rs1, 3'b101, rd, cpuPkg::OPCODE_OP};
      KindAddi: word = {imm[11:0], rs1, 3'b000, rd, cpuPkg::OPCODE_OP_IMM};
      KindAndi: word = {imm[11:0], rs1, 3'b111, rd, cpuPkg::OPCODE_OP_IMM};
      KindOri: word = {imm[11:0], rs1, 3'b110, rd, cpuPkg::OPCODE_OP_IMM};
      KindXori: word = {imm[11:0], rs1, 3'b100, rd, cpuPkg::OPCODE_OP_IMM};
      KindLui: word = {imm[31:12], rd, cpuPkg::OPCODE_LUI};
      KindLw: word = {imm[11:0], rs1, 3'b010, rd, cpuPkg::OPCODE_LOAD};
      KindSw: word = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpuPkg::OPCODE_STORE};
      KindEcall: word = 32'h0000_0073;
      default: word = NopInst;
    endcase
    return word;
  endfunction

  task automatic placeInst(input int idx, input int kind, input cpuPkg::RegAddr rd,
      input cpuPkg::RegAddr rs1, input cpuPkg::RegAddr rs2, input cpuPkg::BasicData imm);
    prog[idx] = encodeInst(kind, rd, rs1, rs2, imm);
    kindOf[idx] = kind;
    rdOf[idx] = rd;
    rs1Of[idx] = rs1;
    rs2Of[idx] = rs2;
    immOf[idx] = imm;
  endtask

  task automatic buildProgram();
    logic [31:0] rnd;
    int kind;
    int word;
    cpuPkg::RegAddr rd;
    cpuPkg::RegAddr rs1;
    cpuPkg::RegAddr rs2;
    cpuPkg::BasicData imm;
    for (int i = 0; i < 256; i++) begin
      prog[i] = NopInst;
    end
    for (int w = 0; w < 64; w++) begin
      written[w] = 1'b0;
    end
    // x8 is the memory base and lies outside the random register pool
    placeInst(0, KindLui, 5'd8, 5'd0, 5'd0, 32'd0);
    placeInst(1, KindAddi, 5'd8, 5'd8, 5'd0, 32'd128);
    for (int i = 2; i < 2 + RandLen; i++) begin
      rnd = $random(seed);
      kind = int'(rnd % 32'd15);
      rnd = $random(seed);
      rd = {2'b00, rnd[2:0]}; // x0..x7 keeps hazards frequent
      rs1 = {2'b00, rnd[5:3]};
      rs2 = {2'b00, rnd[8:6]};
      word = int'(rnd[14:9]);
      imm = {{20{rnd[31]}}, rnd[31:20]};
      if (kind == KindLui) begin
        imm = {rnd[31:12], 12'h000};
      end
      if (kind == KindLw && !written[word]) begin
        kind = KindSw; // never load a word that holds no data yet
      end
      if (kind == KindLw || kind == KindSw) begin
        rs1 = 5'd8;
        imm = 32'(word * 4 - 128); // base 128 covers words 0..63
      end
      if (kind == KindSw) begin
        written[word] = 1'b1;
      end
      placeInst(i, kind, rd, rs1, rs2, imm);
    end
    placeInst(ProgLen - 1, KindEcall, 5'd0, 5'd0, 5'd0, 32'd0);
  endtask

  // in-order ISA model that queues one record per register write
  task automatic runModel();
    cpuPkg::BasicData a;
    cpuPkg::BasicData b;
    cpuPkg::BasicData v;
    cpuPkg::BasicData addr;
    logic writes;
    logic done;
    int i;
    for (int r = 0; r < 32; r++) begin
      modelRegs[r] = '0;
    end
    for (int w = 0; w < 64; w++) begin
      modelMem[w] = '0;
    end
    done = 1'b0;
    i = 0;
    while (!done && i < ProgLen) begin
      a = modelRegs[rs1Of[i]];
      b = modelRegs[rs2Of[i]];
      addr = a + immOf[i];
      writes = 1'b1;
      v = '0;
      case (kindOf[i])
        KindAdd: v = a + b;
        KindSub: v = a - b;
        KindAnd: v = a & b;
        KindOr: v = a | b;
        KindXor: v = a ^ b;
        KindSlt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        KindSll: v = a << b[4:0];
        KindSrl: v = a >> b[4:0];
        KindAddi: v = a + immOf[i];
        KindAndi: v = a & immOf[i];
        KindOri: v = a | immOf[i];
        KindXori: v = a ^ immOf[i];
        KindLui: v = immOf[i];
        KindLw: v = modelMem[addr[7:2]];
        KindSw: begin
          modelMem[addr[7:2]] = b;
          writes = 1'b0;
        end
        default: begin
          writes = 1'b0; // ecall ends the program
          done = 1'b1;
        end
      endcase
      if (writes && rdOf[i] != 5'd0) begin
        modelRegs[rdOf[i]] = v;
        expRd.push_back(rdOf[i]);
        expData.push_back(v);
        expPc.push_back(32'(i * 4));
      end
      i++;
    end
  endtask

  task automatic compareField(input string name, input logic [31:0] got, input logic [31:0] want);
    checkCount++;
    assert (got === want) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, want);
      mismatchCount++;
      errorCount++;
    end
  endtask

  always @(negedge clk) begin
    if (rstN === 1'b1 && retireValid === 1'b1) begin
      retireCount++;
      assert (halted === 1'b0) else begin
        $display("retire pulse at pc %h after the core halted", retirePc);
        errorCount++;
      end
      assert (expRd.size() != 0) else begin
        $display("retire pulse at pc %h with no expected record left", retirePc);
        errorCount++;
      end
      if (expRd.size() != 0) begin
        wantRd = expRd.pop_front();
        wantData = expData.pop_front();
        wantPc = expPc.pop_front();
        compareField("retirePc", retirePc, wantPc);
        compareField("retireRd", {27'b0, retireRd}, {27'b0, wantRd});
        compareField("retireData", retireData, wantData);
      end
    end
  end

  initial begin
    rstN = 1'b0;
    seed = 32'h3b8c_c5a9;
    errorCount = 0;
    mismatchCount = 0;
    checkCount = 0;
    retireCount = 0;
    cycles = 0;
    buildProgram();
    runModel();
    $display("program of %0d words, %0d expected retires", ProgLen, expRd.size());

    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (retireValid === `DISABLE) else begin
      $display("retireValid is high during reset");
      errorCount++;
    end
    assert (halted === `DISABLE) else begin
      $display("halted is high during reset");
      errorCount++;
    end
    @(posedge clk);
    #1 rstN = 1'b1;
    @(negedge clk);
    compareField("instAddr", instAddr, `RESET_PC); // first fetch address

    while (halted !== 1'b1 && cycles < CycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      $display("core never halted within %0d cycles", CycleLimit);
      errorCount++;
    end else begin
      assert (expRd.size() == 0) else begin
        $display("%0d expected retires still missing when the core halted", expRd.size());
        errorCount++;
      end
      for (int k = 0; k < ExtraCycles; k++) begin // monitor flags any late retire
        @(negedge clk);
        assert (halted === 1'b1) else begin
          $display("halted dropped %0d cycles after the core halted", k + 1);
          errorCount++;
        end
      end
    end

    $display("errors %0d, mismatches %0d, checks %0d, retired %0d, cycles %0d",
             errorCount, mismatchCount, checkCount, retireCount, cycles);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/decoder.sv
verilog/decodeStage.sv
verilog/fetchStage.sv
verilog/registerFile.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuCore.sv
dv/cpuCoreTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the cpuCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cpuCoreTb -Mdir obj_dir -f build.f

./obj_dir/VcpuCoreTb > sim.log 2>&1
cat sim.log

if grep -q "all tests passed" sim.log; then
  exit 0
else
  exit 1
fi
